// File: Makefile
# Verilator build and run of the status subsystem testbench

VERILATOR ?= verilator
FILELIST  ?= sources.f
TOP       ?= status_subsystem_tb
RTL_TOP   ?= status_subsystem
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^test passed$$" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/mac_status_regs.sv
/* MAC status registers: revision, scratch and the rx and tx frame counters,
   decoded on the MAC page with a one cycle read response */
`timescale 1ns/1ps
`default_nettype none

module mac_status_regs
    import status_map_pkg::*, status_reg_pkg::*;
(
    input  wire                clk_status,
    input  wire                rst_n,
    input  wire [addr_w-1:0]   status_addr,
    input  wire                status_read,
    input  wire                status_write,
    input  wire [31:0]         status_writedata,
    input  wire                rx_frame,
    input  wire                tx_frame,
    output logic [31:0]        mac_readdata,
    output logic               mac_valid
);

    logic [page_w-1:0]        page;
    logic [offset_w-1:0]      offset;
    logic                     rd_sel;
    logic                     wr_sel;
    logic                     clear_cnt;
    logic [31:0]              scratch;
    logic [frame_count_w-1:0] rx_count;
    logic [frame_count_w-1:0] tx_count;
    logic [31:0]              rd_mux;

    // the host bus reaches both blocks unchanged, so each one checks its own page
    assign page   = status_addr[addr_w-1:offset_w];
    assign offset = status_addr[offset_w-1:0];
    assign rd_sel = status_read && (page == mac_page);
    assign wr_sel = status_write && (page == mac_page);

    // any write to the clear offset zeroes both counters, whatever the data
    assign clear_cnt = wr_sel && (offset == reg_clear);

    always_ff @(posedge clk_status) begin
        if (!rst_n) begin
            scratch <= '0;
        end else if (wr_sel && (offset == reg_scratch)) begin
            scratch <= status_writedata;
        end
    end

    // clear wins over a frame pulse seen in the same cycle
    always_ff @(posedge clk_status) begin
        if (!rst_n) begin
            rx_count <= '0;
            tx_count <= '0;
        end else if (clear_cnt) begin
            rx_count <= '0;
            tx_count <= '0;
        end else begin
            if (rx_frame) begin
                rx_count <= rx_count + 1'b1;
            end
            if (tx_frame) begin
                tx_count <= tx_count + 1'b1;
            end
        end
    end

    // unused offsets read as zero
    always_comb begin
        case (offset)
            reg_revision: rd_mux = mac_revision;
            reg_scratch:  rd_mux = scratch;
            reg_count_a:  rd_mux = 32'(rx_count);
            reg_count_b:  rd_mux = 32'(tx_count);
            default:      rd_mux = '0;
        endcase
    end

    // the response must stay zero while valid is low so the bridge can OR it
    always_ff @(posedge clk_status) begin
        if (!rst_n) begin
            mac_valid    <= 1'b0;
            mac_readdata <= '0;
        end else begin
            mac_valid    <= rd_sel;
            mac_readdata <= rd_sel ? rd_mux : '0;
        end
    end

endmodule

`default_nettype wire

// File: design/phy_status_regs.sv
/* PHY status registers: revision, scratch, live and sticky lane lock and a
   saturating symbol error counter, with a two stage read response */
`timescale 1ns/1ps
`default_nettype none

module phy_status_regs
    import status_map_pkg::*, status_reg_pkg::*;
#(
    parameter int lanes = 4
) (
    input  wire                clk_status,
    input  wire                rst_n,
    input  wire [addr_w-1:0]   status_addr,
    input  wire                status_read,
    input  wire                status_write,
    input  wire [31:0]         status_writedata,
    input  wire [lanes-1:0]    lane_locked,
    input  wire                symbol_error,
    output logic [31:0]        phy_readdata,
    output logic               phy_valid
);

    logic [page_w-1:0]         page;
    logic [offset_w-1:0]       offset;
    logic                      rd_sel;
    logic                      wr_sel;
    logic [31:0]               scratch;
    logic [lanes-1:0]          locked_q;
    logic [lanes-1:0]          lock_fall;
    logic [lanes-1:0]          sticky_clr;
    logic [lanes-1:0]          lock_lost;
    logic [symbol_error_w-1:0] sym_count;
    logic [31:0]               rd_mux;
    logic [31:0]               stage1_data;
    logic                      stage1_valid;

    assign page   = status_addr[addr_w-1:offset_w];
    assign offset = status_addr[offset_w-1:0];
    assign rd_sel = status_read && (page == phy_page);
    assign wr_sel = status_write && (page == phy_page);

    always_ff @(posedge clk_status) begin
        if (!rst_n) begin
            scratch <= '0;
        end else if (wr_sel && (offset == reg_scratch)) begin
            scratch <= status_writedata;
        end
    end

    // a lane that was locked last cycle and is not now has lost lock
    assign lock_fall = locked_q & ~lane_locked;

    // write one to clear, one bit per lane
    assign sticky_clr = (wr_sel && (offset == reg_count_b)) ?
                        status_writedata[lanes-1:0] : '0;

    // a new fall in the clear cycle keeps its sticky bit set
    always_ff @(posedge clk_status) begin
        if (!rst_n) begin
            locked_q  <= '0;
            lock_lost <= '0;
        end else begin
            locked_q  <= lane_locked;
            lock_lost <= (lock_lost & ~sticky_clr) | lock_fall;
        end
    end

    // the counter holds at all ones and any write to its offset zeroes it
    always_ff @(posedge clk_status) begin
        if (!rst_n) begin
            sym_count <= '0;
        end else if (wr_sel && (offset == reg_clear)) begin
            sym_count <= '0;
        end else if (symbol_error && (sym_count != '1)) begin
            sym_count <= sym_count + 1'b1;
        end
    end

    always_comb begin
        case (offset)
            reg_revision: rd_mux = phy_revision;
            reg_scratch:  rd_mux = scratch;
            reg_count_a:  rd_mux = 32'(lane_locked);
            reg_count_b:  rd_mux = 32'(lock_lost);
            reg_clear:    rd_mux = 32'(sym_count);
            default:      rd_mux = '0;
        endcase
    end

    // two register stages, both zero while their valid is low
    always_ff @(posedge clk_status) begin
        if (!rst_n) begin
            stage1_valid <= 1'b0;
            stage1_data  <= '0;
            phy_valid    <= 1'b0;
            phy_readdata <= '0;
        end else begin
            stage1_valid <= rd_sel;
            stage1_data  <= rd_sel ? rd_mux : '0;
            phy_valid    <= stage1_valid;
            phy_readdata <= stage1_data;
        end
    end

endmodule

`default_nettype wire

// File: design/status_bridge.sv
/* status response bridge: ORs the block answers into one registered host
   response, times out unmapped reads and synchronizes the PMA reset */
`timescale 1ns/1ps
`default_nettype none

module status_bridge
    import status_reg_pkg::*;
#(
    parameter int read_timeout = 8
) (
    input  wire         clk_status,
    input  wire         rst_n,
    input  wire         status_read,
    input  wire [31:0]  mac_readdata,
    input  wire         mac_valid,
    input  wire [31:0]  phy_readdata,
    input  wire         phy_valid,
    input  wire         pma_arst_st,
    output logic [31:0] status_readdata,
    output logic        status_readdata_valid,
    output logic        pma_arst_st_out
);

    // the counter has to hold the value read_timeout itself
    localparam int cnt_w = $clog2(read_timeout + 1);

    logic             any_valid;
    logic             pending;
    logic [cnt_w-1:0] wait_cnt;
    logic             timed_out;
    logic [1:0]       pma_sync;

    assign any_valid = mac_valid || phy_valid;

    // wait_cnt equals the number of cycles since the read strobe
    assign timed_out = pending && !any_valid && (wait_cnt == cnt_w'(read_timeout));

    // only one read is ever outstanding, so a single counter is enough
    always_ff @(posedge clk_status) begin
        if (!rst_n) begin
            pending  <= 1'b0;
            wait_cnt <= '0;
        end else if (status_read) begin
            pending  <= 1'b1;
            wait_cnt <= cnt_w'(1);
        end else if (any_valid || timed_out) begin
            pending  <= 1'b0;
            wait_cnt <= '0;
        end else if (pending) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // the blocks keep their data at zero when idle, so an OR merges them
    always_ff @(posedge clk_status) begin
        if (!rst_n) begin
            status_readdata_valid <= 1'b0;
            status_readdata       <= '0;
        end else begin
            status_readdata_valid <= any_valid || timed_out;
            if (any_valid) begin
                status_readdata <= mac_readdata | phy_readdata;
            end else if (timed_out) begin
                status_readdata <= error_word;
            end else begin
                status_readdata <= '0;
            end
        end
    end

    // two flop synchronizer, held in reset until rst_n is released
    always_ff @(posedge clk_status) begin
        if (!rst_n) begin
            pma_sync <= 2'b11;
        end else begin
            pma_sync <= {pma_sync[0], pma_arst_st};
        end
    end

    assign pma_arst_st_out = pma_sync[1];

endmodule

`default_nettype wire

// File: design/status_map_pkg.sv
/* status bus address map: page and offset field widths, block page numbers
   and the register offsets shared by the MAC and PHY status blocks */
`default_nettype none

package status_map_pkg;

    // the upper address bits select a block page, the lower bits a register
    localparam int page_w   = 8;
    localparam int offset_w = 8;
    localparam int addr_w   = page_w + offset_w;

    // pages decoded by each status block
    localparam logic [page_w-1:0] mac_page = 'h00;
    localparam logic [page_w-1:0] phy_page = 'h01;

    // register offsets inside a page, with the same layout in both blocks
    localparam logic [offset_w-1:0] reg_revision = 'h00;
    localparam logic [offset_w-1:0] reg_scratch  = 'h01;

    // rx frame count in the MAC, live lane lock in the PHY
    localparam logic [offset_w-1:0] reg_count_a  = 'h02;

    // tx frame count in the MAC, sticky lock loss in the PHY
    localparam logic [offset_w-1:0] reg_count_b  = 'h03;

    // counter clear in the MAC, symbol error count in the PHY
    localparam logic [offset_w-1:0] reg_clear    = 'h04;

endpackage

`default_nettype wire

// File: design/status_reg_pkg.sv
/* register contents: block revision codes, the unmapped read error word
   and the widths of the status counters */
`default_nettype none

package status_reg_pkg;

    // read-only revision codes returned at reg_revision
    localparam logic [31:0] mac_revision = 32'h100e_0102;
    localparam logic [31:0] phy_revision = 32'h100e_0201;

    // returned by the bridge when no block answers a read in time
    localparam logic [31:0] error_word = 32'hbad0_0bad;

    // MAC frame counters wrap at this width
    localparam int frame_count_w = 32;

    // PHY symbol error counter saturates at its maximum value
    localparam int symbol_error_w = 16;

endpackage

`default_nettype wire

// File: design/status_subsystem.sv
/* status subsystem top level: fans the host status bus out to the MAC and
   PHY register blocks and returns their answers through the bridge */
`timescale 1ns/1ps
`default_nettype none

module status_subsystem
    import status_map_pkg::*;
#(
    parameter int lanes        = 4,
    parameter int read_timeout = 8
) (
    input  wire                clk_status,
    input  wire                rst_n,
    input  wire [addr_w-1:0]   status_addr,
    input  wire                status_read,
    input  wire                status_write,
    input  wire [31:0]         status_writedata,
    output logic [31:0]        status_readdata,
    output logic               status_readdata_valid,
    input  wire                rx_frame,
    input  wire                tx_frame,
    input  wire [lanes-1:0]    lane_locked,
    input  wire                symbol_error,
    input  wire                pma_arst_st,
    output logic               pma_arst_st_out
);

    // block answers, each zero while its valid is low
    logic [31:0] mac_readdata;
    logic        mac_valid;
    logic [31:0] phy_readdata;
    logic        phy_valid;

    // both blocks see the same bus and decode their own page
    mac_status_regs i_mac_status_regs (
        .clk_status       (clk_status),
        .rst_n            (rst_n),
        .status_addr      (status_addr),
        .status_read      (status_read),
        .status_write     (status_write),
        .status_writedata (status_writedata),
        .rx_frame         (rx_frame),
        .tx_frame         (tx_frame),
        .mac_readdata     (mac_readdata),
        .mac_valid        (mac_valid)
    );

    phy_status_regs #(
        .lanes (lanes)
    ) i_phy_status_regs (
        .clk_status       (clk_status),
        .rst_n            (rst_n),
        .status_addr      (status_addr),
        .status_read      (status_read),
        .status_write     (status_write),
        .status_writedata (status_writedata),
        .lane_locked      (lane_locked),
        .symbol_error     (symbol_error),
        .phy_readdata     (phy_readdata),
        .phy_valid        (phy_valid)
    );

    // the read strobe also starts the timeout for unmapped pages
    status_bridge #(
        .read_timeout (read_timeout)
    ) i_status_bridge (
        .clk_status            (clk_status),
        .rst_n                 (rst_n),
        .status_read           (status_read),
        .mac_readdata          (mac_readdata),
        .mac_valid             (mac_valid),
        .phy_readdata          (phy_readdata),
        .phy_valid             (phy_valid),
        .pma_arst_st           (pma_arst_st),
        .status_readdata       (status_readdata),
        .status_readdata_valid (status_readdata_valid),
        .pma_arst_st_out       (pma_arst_st_out)
    );

endmodule

`default_nettype wire

// File: dv/status_subsystem_tb.sv
/* clock and reset, host bus tasks and a register model for the status subsystem,
   with assertions on every read response and on the PMA reset output */
`timescale 1ns/1ps
`default_nettype none

module status_subsystem_tb
    import status_map_pkg::*, status_reg_pkg::*;
();

    localparam int lanes        = 4;
    localparam int read_timeout = 8;
    localparam int pipe_depth   = 16;
    localparam int wait_limit   = read_timeout + 8;

    logic              clk_status;
    logic              rst_n;
    logic [addr_w-1:0] status_addr;
    logic              status_read;
    logic              status_write;
    logic [31:0]       status_writedata;
    logic [31:0]       status_readdata;
    logic              status_readdata_valid;
    logic              rx_frame;
    logic              tx_frame;
    logic [lanes-1:0]  lane_locked;
    logic              symbol_error;
    logic              pma_arst_st;
    logic              pma_arst_st_out;

    // slot 0 of the expected response line is what the bus must show at the current edge
    logic [pipe_depth-1:0]       exp_valid;
    logic [pipe_depth-1:0][31:0] exp_data;
    logic                        sched_en;
    logic [3:0]                  sched_idx;
    logic [31:0]                 sched_data;

    // register model
    logic [31:0]               mac_scratch;
    logic [31:0]               phy_scratch;
    logic [31:0]               rx_count;
    logic [31:0]               tx_count;
    logic [lanes-1:0]          lock_now;
    logic [lanes-1:0]          sticky;
    logic [symbol_error_w-1:0] sym_count;
    integer                    seed;

    status_subsystem #(
        .lanes        (lanes),
        .read_timeout (read_timeout)
    ) i_dut (
        .clk_status            (clk_status),
        .rst_n                 (rst_n),
        .status_addr           (status_addr),
        .status_read           (status_read),
        .status_write          (status_write),
        .status_writedata      (status_writedata),
        .status_readdata       (status_readdata),
        .status_readdata_valid (status_readdata_valid),
        .rx_frame              (rx_frame),
        .tx_frame              (tx_frame),
        .lane_locked           (lane_locked),
        .symbol_error          (symbol_error),
        .pma_arst_st           (pma_arst_st),
        .pma_arst_st_out       (pma_arst_st_out)
    );

    initial begin
        clk_status = 1'b0;
        forever #50 clk_status = ~clk_status;
    end

    // a read seen by the DUT at this edge lands in the slot of its latency minus one
    always @(posedge clk_status) begin
        exp_valid <= exp_valid >> 1;
        exp_data  <= exp_data >> 32;
        if (sched_en) begin
            exp_valid[sched_idx] <= 1'b1;
            exp_data[sched_idx]  <= sched_data;
        end
    end

    // valid must come exactly when expected and never otherwise
    read_valid_check: assert property (@(posedge clk_status) disable iff (!rst_n)
        status_readdata_valid == exp_valid[0])
        else report_mismatch($sformatf("read data valid %0b, expected %0b",
                                       $sampled(status_readdata_valid),
                                       $sampled(exp_valid[0])));

    read_data_check: assert property (@(posedge clk_status) disable iff (!rst_n)
        status_readdata_valid |-> status_readdata == exp_data[0])
        else report_mismatch($sformatf("read data 0x%08h, expected 0x%08h",
                                       $sampled(status_readdata),
                                       $sampled(exp_data[0])));

    // the PMA reset output is its input delayed by two clock cycles
    pma_sync_check: assert property (@(posedge clk_status) disable iff (!rst_n)
        pma_arst_st_out == $past(pma_arst_st, 2))
        else report_mismatch($sformatf("pma reset output %0b differs from its input two cycles earlier",
                                       $sampled(pma_arst_st_out)));

    task automatic abort_sim();
        $display("test failed");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic report_mismatch(input string msg);
        $display("error %0t ns: %s", $time, msg);
        abort_sim();
    endtask

    task automatic report_timeout(input string what);
        $display("timed out at %0t ns while waiting for %s", $time, what);
        abort_sim();
    endtask

    // the value a read must return is taken from the model at the time of the read
    function automatic logic [31:0] expected_read(input logic [addr_w-1:0] addr);
        logic [page_w-1:0]   page;
        logic [offset_w-1:0] offset;
        logic [31:0]         value;
        page   = addr[addr_w-1:offset_w];
        offset = addr[offset_w-1:0];
        value  = '0;
        if (page == mac_page) begin
            case (offset)
                reg_revision: value = mac_revision;
                reg_scratch:  value = mac_scratch;
                reg_count_a:  value = rx_count;
                reg_count_b:  value = tx_count;
                default:      value = '0;
            endcase
        end else if (page == phy_page) begin
            case (offset)
                reg_revision: value = phy_revision;
                reg_scratch:  value = phy_scratch;
                reg_count_a:  value = 32'(lock_now);
                reg_count_b:  value = 32'(sticky);
                reg_clear:    value = 32'(sym_count);
                default:      value = '0;
            endcase
        end else begin
            value = error_word;
        end
        return value;
    endfunction

    task automatic write_reg(input logic [addr_w-1:0] addr, input logic [31:0] data);
        logic [page_w-1:0]   page;
        logic [offset_w-1:0] offset;
        page   = addr[addr_w-1:offset_w];
        offset = addr[offset_w-1:0];
        @(posedge clk_status);
        status_addr      <= addr;
        status_write     <= 1'b1;
        status_writedata <= data;
        @(posedge clk_status);
        status_write <= 1'b0;
        if (page == mac_page) begin
            if (offset == reg_scratch) begin
                mac_scratch = data;
            end
            if (offset == reg_clear) begin
                rx_count = '0;
                tx_count = '0;
            end
        end else if (page == phy_page) begin
            if (offset == reg_scratch) begin
                phy_scratch = data;
            end
            // sticky lock loss is write one to clear
            if (offset == reg_count_b) begin
                sticky = sticky & ~data[lanes-1:0];
            end
            if (offset == reg_clear) begin
                sym_count = '0;
            end
        end
    endtask

    // the MAC answers 2 cycles after the read, the PHY 3 and an unmapped page read_timeout+1
    task automatic read_reg(input logic [addr_w-1:0] addr);
        logic [page_w-1:0] page;
        int                waited;
        logic              seen;
        page = addr[addr_w-1:offset_w];
        @(posedge clk_status);
        status_addr <= addr;
        status_read <= 1'b1;
        sched_en    <= 1'b1;
        sched_data  <= expected_read(addr);
        if (page == mac_page) begin
            sched_idx <= 4'd1;
        end else if (page == phy_page) begin
            sched_idx <= 4'd2;
        end else begin
            sched_idx <= 4'(read_timeout);
        end
        @(posedge clk_status);
        status_read <= 1'b0;
        sched_en    <= 1'b0;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < wait_limit) begin
            @(posedge clk_status);
            seen   = status_readdata_valid;
            waited = waited + 1;
        end
        if (!seen) begin
            report_timeout("read data valid");
        end
    endtask

    // drives random rx and tx pulse trains and counts them into the model as they go out
    task automatic send_frames(input int cycles);
        logic [31:0] r;
        int          n;
        for (n = 0; n < cycles; n++) begin
            @(posedge clk_status);
            r = $random(seed);
            rx_frame <= r[0];
            tx_frame <= r[1];
            if (r[0]) begin
                rx_count = rx_count + 32'd1;
            end
            if (r[1]) begin
                tx_count = tx_count + 32'd1;
            end
        end
        @(posedge clk_status);
        rx_frame <= 1'b0;
        tx_frame <= 1'b0;
    endtask

    task automatic hold_symbol_error(input int cycles);
        int n;
        for (n = 0; n < cycles; n++) begin
            @(posedge clk_status);
            symbol_error <= 1'b1;
            if (sym_count != {symbol_error_w{1'b1}}) begin
                sym_count = sym_count + 1'b1;
            end
        end
        @(posedge clk_status);
        symbol_error <= 1'b0;
    endtask

    // a lane that drops from locked sets its sticky bit
    task automatic set_lanes(input logic [lanes-1:0] pattern);
        @(posedge clk_status);
        lane_locked <= pattern;
        sticky   = sticky | (lock_now & ~pattern);
        lock_now = pattern;
    endtask

    task automatic wait_pma_out(input logic level);
        int   waited;
        logic seen;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < 6) begin
            @(posedge clk_status);
            seen   = (pma_arst_st_out == level);
            waited = waited + 1;
        end
        if (!seen) begin
            report_timeout("the pma reset output to follow its input");
        end
    endtask

    initial begin
        int          i;
        logic [31:0] r;
        seed             = 36708;
        rst_n            = 1'b0;
        status_addr      = '0;
        status_read      = 1'b0;
        status_write     = 1'b0;
        status_writedata = '0;
        rx_frame         = 1'b0;
        tx_frame         = 1'b0;
        lane_locked      = '0;
        symbol_error     = 1'b0;
        pma_arst_st      = 1'b1;
        exp_valid        = '0;
        exp_data         = '0;
        sched_en         = 1'b0;
        sched_idx        = '0;
        sched_data       = '0;
        mac_scratch      = '0;
        phy_scratch      = '0;
        rx_count         = '0;
        tx_count         = '0;
        lock_now         = '0;
        sticky           = '0;
        sym_count        = '0;

        repeat (16) @(posedge clk_status);
        rst_n <= 1'b1;
        // mid-cycle after the last reset edge the outputs still hold their reset values
        @(negedge clk_status);
        assert (status_readdata_valid == 1'b0)
            else report_mismatch("read data valid high after reset");
        assert (pma_arst_st_out == 1'b1)
            else report_mismatch("pma reset output low after reset");

        // revision codes and the cleared state of every register
        read_reg({mac_page, reg_revision});
        read_reg({phy_page, reg_revision});
        read_reg({mac_page, reg_scratch});
        read_reg({mac_page, reg_count_a});
        read_reg({mac_page, reg_count_b});
        read_reg({phy_page, reg_scratch});
        read_reg({phy_page, reg_count_b});
        read_reg({phy_page, reg_clear});

        // scratch writes on one page must leave the other page alone
        for (i = 0; i < 4; i++) begin
            write_reg({mac_page, reg_scratch}, $random(seed));
            read_reg({mac_page, reg_scratch});
            read_reg({phy_page, reg_scratch});
            write_reg({phy_page, reg_scratch}, $random(seed));
            read_reg({phy_page, reg_scratch});
            read_reg({mac_page, reg_scratch});
        end

        send_frames(200);
        read_reg({mac_page, reg_count_a});
        read_reg({mac_page, reg_count_b});
        send_frames(57);
        read_reg({mac_page, reg_count_a});
        read_reg({mac_page, reg_count_b});
        write_reg({mac_page, reg_clear}, $random(seed));
        read_reg({mac_page, reg_count_a});
        read_reg({mac_page, reg_count_b});
        read_reg({mac_page, 8'h07});

        set_lanes(4'b1111);
        read_reg({phy_page, reg_count_a});
        read_reg({phy_page, reg_count_b});
        set_lanes(4'b1011);
        read_reg({phy_page, reg_count_a});
        read_reg({phy_page, reg_count_b});
        set_lanes(4'b0011);
        read_reg({phy_page, reg_count_b});
        write_reg({phy_page, reg_count_b}, 32'h0000_0004);
        read_reg({phy_page, reg_count_b});
        for (i = 0; i < 6; i++) begin
            r = $random(seed);
            set_lanes(r[lanes-1:0]);
            read_reg({phy_page, reg_count_a});
            read_reg({phy_page, reg_count_b});
        end
        write_reg({phy_page, reg_count_b}, 32'hffff_ffff);
        read_reg({phy_page, reg_count_b});

        // past the counter maximum the value must stay at all ones
        hold_symbol_error(100);
        read_reg({phy_page, reg_clear});
        hold_symbol_error(70000);
        read_reg({phy_page, reg_clear});
        write_reg({phy_page, reg_clear}, $random(seed));
        read_reg({phy_page, reg_clear});

        read_reg({8'h05, reg_revision});
        read_reg({8'hff, reg_count_b});

        @(posedge clk_status);
        pma_arst_st <= 1'b0;
        wait_pma_out(1'b0);
        @(posedge clk_status);
        pma_arst_st <= 1'b1;
        wait_pma_out(1'b1);

        repeat (4) @(posedge clk_status);
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
design/status_map_pkg.sv
design/status_reg_pkg.sv
design/mac_status_regs.sv
design/phy_status_regs.sv
design/status_bridge.sv
design/status_subsystem.sv
dv/status_subsystem_tb.sv
